//--- nes_glue_pkg.sv
`default_nettype none

package nes_glue_pkg;

  // memory request port
  localparam int ADDR_W = 22;
  localparam int DATA_W = 8;

  // audio
  localparam int SAMPLE_W = 16;

  // console clock-enable phase
  localparam int                CE_W           = 2;
  localparam logic [CE_W-1:0]   CE_WRITE_PHASE = 2'd3;   // loader write slot

  // reset sequencing
  localparam int POR_CYCLES      = 32;   // short hold for simulation
  localparam int POR_W           = 6;
  localparam int DL_RESET_CYCLES = 255;  // hold after load done
  localparam int DL_W            = 8;

  typedef enum logic [2:0] {
    RST_WAIT_LOCK = 3'd0,  // pll not locked yet
    RST_POR_HOLD  = 3'd1,  // power-on hold count
    RST_WAIT_LOAD = 3'd2,  // until first download done
    RST_POST_LOAD = 3'd3,  // post-download hold count
    RST_RUN       = 3'd4
  } rst_state_e;

  // bit positions of the joypad byte, shifted out from BTN_A
  typedef enum logic [2:0] {
    BTN_A      = 3'd0,
    BTN_B      = 3'd1,
    BTN_SELECT = 3'd2,
    BTN_START  = 3'd3,
    BTN_UP     = 3'd4,
    BTN_DOWN   = 3'd5,
    BTN_LEFT   = 3'd6,
    BTN_RIGHT  = 3'd7
  } joy_button_e;

endpackage

`default_nettype wire

//--- reset_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module reset_sequencer
  import nes_glue_pkg::*;
(
  input  wire  clock,
  input  wire  rst_n_i,
  input  wire  pll_locked_i,
  input  wire  reset_button_i,
  input  wire  load_done_i,
  input  wire  loader_write_i,   // first strobe marks download start
  output logic reset_nes_o
);

  rst_state_e       state_q;
  logic [POR_W-1:0] por_cnt_q;
  logic [DL_W-1:0]  dl_cnt_q;
  logic             dl_started_q;
  logic             abort;

  // lock loss or button restarts the whole sequence
  assign abort = !pll_locked_i || reset_button_i;

  always_ff @(posedge clock)
  begin
    if (!rst_n_i)
    begin
      state_q      <= RST_WAIT_LOCK;
      por_cnt_q    <= '0;
      dl_cnt_q     <= '0;
      dl_started_q <= 1'b0;
      reset_nes_o  <= 1'b1;
    end
    else
    begin
      // console held in reset unless running with a loaded cartridge
      reset_nes_o <= abort || !load_done_i || (state_q != RST_RUN);

      if (!pll_locked_i)
        dl_started_q <= 1'b0;     // sticky until lock is lost
      else if (loader_write_i)
        dl_started_q <= 1'b1;

      if (abort)
      begin
        state_q   <= RST_WAIT_LOCK;
        por_cnt_q <= '0;
        dl_cnt_q  <= '0;
      end
      else
      begin
        case (state_q)
          RST_WAIT_LOCK:
          begin
            state_q   <= RST_POR_HOLD;   // lock is present here
            por_cnt_q <= POR_W'(POR_CYCLES - 1);
          end
          RST_POR_HOLD:
          begin
            if (por_cnt_q == '0)
              state_q <= RST_WAIT_LOAD;
            else
              por_cnt_q <= por_cnt_q - 1'b1;
          end
          RST_WAIT_LOAD:
          begin
            if (dl_started_q && load_done_i)
            begin
              state_q  <= RST_POST_LOAD;
              dl_cnt_q <= DL_W'(DL_RESET_CYCLES - 1);
            end
          end
          RST_POST_LOAD:
          begin
            if (!load_done_i)
              state_q <= RST_WAIT_LOAD;   // new download started
            else if (dl_cnt_q == '0)
              state_q <= RST_RUN;
            else
              dl_cnt_q <= dl_cnt_q - 1'b1;
          end
          RST_RUN:
          begin
            if (!load_done_i)
              state_q <= RST_WAIT_LOAD;
          end
          default:
            state_q <= RST_WAIT_LOCK;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- load_write_stage.sv
`timescale 1ns/1ns
`default_nettype none

module load_write_stage
  import nes_glue_pkg::*;
(
  input  wire               clock,
  input  wire               rst_n_i,
  input  wire               load_done_i,
  input  wire  [CE_W-1:0]   nes_ce_i,
  input  wire               loader_write_i,
  input  wire  [ADDR_W-1:0] loader_addr_i,
  input  wire  [DATA_W-1:0] loader_data_i,
  input  wire  [ADDR_W-1:0] cpu_addr_i,
  input  wire  [DATA_W-1:0] cpu_wdata_i,
  input  wire               cpu_we_i,
  input  wire               cpu_oe_i,
  output logic [ADDR_W-1:0] mem_addr_o,
  output logic [DATA_W-1:0] mem_wdata_o,
  output logic              mem_we_o,
  output logic              mem_oe_o
);

  logic [ADDR_W-1:0] cap_addr_q;   // pending capture
  logic [DATA_W-1:0] cap_data_q;
  logic              pending_q;
  logic [ADDR_W-1:0] iss_addr_q;   // write on the memory port
  logic [DATA_W-1:0] iss_data_q;
  logic              iss_we_q;
  logic              write_phase;

  assign write_phase = (nes_ce_i == CE_WRITE_PHASE);

  always_ff @(posedge clock)
  begin
    if (!rst_n_i)
    begin
      pending_q <= 1'b0;
      iss_we_q  <= 1'b0;
    end
    else if (write_phase)
    begin
      iss_we_q  <= pending_q;        // held for one full phase period
      pending_q <= loader_write_i;   // strobe in the slot waits a period
    end
    else if (loader_write_i)
      pending_q <= 1'b1;
  end

  always_ff @(posedge clock)
  begin
    if (loader_write_i)
    begin
      cap_addr_q <= loader_addr_i;   // later strobe overwrites
      cap_data_q <= loader_data_i;
    end
    if (write_phase && pending_q)
    begin
      iss_addr_q <= cap_addr_q;
      iss_data_q <= cap_data_q;
    end
  end

  // loader owns the port until load done, cpu after
  always_comb
  begin
    if (load_done_i)
    begin
      mem_addr_o  = cpu_addr_i;
      mem_wdata_o = cpu_wdata_i;
      mem_we_o    = cpu_we_i;
      mem_oe_o    = cpu_oe_i;
    end
    else
    begin
      mem_addr_o  = iss_addr_q;
      mem_wdata_o = iss_data_q;
      mem_we_o    = iss_we_q;
      mem_oe_o    = 1'b0;         // no reads while loading
    end
  end

endmodule

`default_nettype wire

//--- joypad_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module joypad_serializer
  import nes_glue_pkg::*;
(
  input  wire        clock,
  input  wire        rst_n_i,
  input  wire        joy_strobe_i,
  input  wire        joy_clock_i,
  input  wire        board_start_i,
  input  wire        board_a_i,
  input  wire  [7:0] usb_buttons_i,   // joy_button_e order
  output logic       joy_data_o
);

  logic       start_q;
  logic       a_q;
  logic [7:0] board_byte;
  logic [7:0] shift_q;
  logic       joy_clock_q;
  logic       joy_clock_fall;

  always_ff @(posedge clock)
  begin
    start_q <= board_start_i;   // one register stage
    a_q     <= board_a_i;
  end

  always_comb
  begin
    board_byte            = '0;
    board_byte[BTN_START] = start_q;
    board_byte[BTN_A]     = a_q;
  end

  assign joy_clock_fall = joy_clock_q && !joy_clock_i;

  always_ff @(posedge clock)
  begin
    if (!rst_n_i)
    begin
      shift_q     <= '0;
      joy_clock_q <= 1'b0;
    end
    else
    begin
      joy_clock_q <= joy_clock_i;
      if (joy_strobe_i)
        shift_q <= board_byte | usb_buttons_i;   // reload while strobe high
      else if (joy_clock_fall)
        shift_q <= {1'b0, shift_q[7:1]};         // zeros shift in
    end
  end

  assign joy_data_o = shift_q[BTN_A];

endmodule

`default_nettype wire

//--- sigma_delta_dac.sv
`timescale 1ns/1ns
`default_nettype none

module sigma_delta_dac
  import nes_glue_pkg::*;
(
  input  wire                 clock,
  input  wire                 reset_nes_i,
  input  wire  [SAMPLE_W-1:0] sample_i,
  output logic                audio_o
);

  // top bit holds the carry of the last add
  logic [SAMPLE_W:0] acc_q;

  always_ff @(posedge clock)
  begin
    if (reset_nes_i)
      acc_q <= '0;   // silent while console in reset
    else
      acc_q <= {1'b0, acc_q[SAMPLE_W-1:0]} + {1'b0, sample_i};
  end

  // carry density follows sample / 2**SAMPLE_W, muted from the first reset cycle
  assign audio_o = acc_q[SAMPLE_W] && !reset_nes_i;

endmodule

`default_nettype wire

//--- nes_glue_top.sv
`timescale 1ns/1ns
`default_nettype none

module nes_glue_top
  import nes_glue_pkg::*;
(
  input  wire                 clock,
  input  wire                 rst_n_i,
  input  wire                 pll_locked_i,
  input  wire                 reset_button_i,
  input  wire                 load_done_i,
  // cartridge loader byte stream
  input  wire                 loader_write_i,
  input  wire  [ADDR_W-1:0]   loader_addr_i,
  input  wire  [DATA_W-1:0]   loader_data_i,
  input  wire  [CE_W-1:0]     nes_ce_i,
  // cpu side of the memory port
  input  wire  [ADDR_W-1:0]   cpu_addr_i,
  input  wire  [DATA_W-1:0]   cpu_wdata_i,
  input  wire                 cpu_we_i,
  input  wire                 cpu_oe_i,
  output logic [ADDR_W-1:0]   mem_addr_o,
  output logic [DATA_W-1:0]   mem_wdata_o,
  output logic                mem_we_o,
  output logic                mem_oe_o,
  // joypad
  input  wire                 joy_strobe_i,
  input  wire                 joy_clock_i,
  input  wire                 board_start_i,
  input  wire                 board_a_i,
  input  wire  [7:0]          usb_buttons_i,
  output logic                joy_data_o,
  // audio
  input  wire  [SAMPLE_W-1:0] sample_i,
  output logic                audio_o,
  output logic                reset_nes_o
);

  reset_sequencer reset_sequencer_inst (
    .clock          (clock),
    .rst_n_i        (rst_n_i),
    .pll_locked_i   (pll_locked_i),
    .reset_button_i (reset_button_i),
    .load_done_i    (load_done_i),
    .loader_write_i (loader_write_i),
    .reset_nes_o    (reset_nes_o)
  );

  load_write_stage load_write_stage_inst (
    .clock          (clock),
    .rst_n_i        (rst_n_i),
    .load_done_i    (load_done_i),
    .nes_ce_i       (nes_ce_i),
    .loader_write_i (loader_write_i),
    .loader_addr_i  (loader_addr_i),
    .loader_data_i  (loader_data_i),
    .cpu_addr_i     (cpu_addr_i),
    .cpu_wdata_i    (cpu_wdata_i),
    .cpu_we_i       (cpu_we_i),
    .cpu_oe_i       (cpu_oe_i),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_we_o       (mem_we_o),
    .mem_oe_o       (mem_oe_o)
  );

  joypad_serializer joypad_serializer_inst (
    .clock          (clock),
    .rst_n_i        (rst_n_i),
    .joy_strobe_i   (joy_strobe_i),
    .joy_clock_i    (joy_clock_i),
    .board_start_i  (board_start_i),
    .board_a_i      (board_a_i),
    .usb_buttons_i  (usb_buttons_i),
    .joy_data_o     (joy_data_o)
  );

  // audio is muted by the console reset
  sigma_delta_dac sigma_delta_dac_inst (
    .clock          (clock),
    .reset_nes_i    (reset_nes_o),
    .sample_i       (sample_i),
    .audio_o        (audio_o)
  );

endmodule

`default_nettype wire

//--- nes_glue_chk.sv
`timescale 1ns/1ns
`default_nettype none

module nes_glue_chk
  import nes_glue_pkg::*;
(
  input wire clock,
  input wire rst_n_i,
  input wire pll_locked_i,
  input wire load_done_i,
  input wire mem_we_i,
  input wire reset_nes_i,
  input wire audio_i
);

  // lock loss forces the console into reset on the next edge
  assert property (@(posedge clock) disable iff (!rst_n_i)
    !pll_locked_i |=> reset_nes_i)
    else $error("console reset not asserted after lock loss");

  // a loader write occupies one full phase period
  assert property (@(posedge clock) disable iff (!rst_n_i)
    $rose(mem_we_i) && !load_done_i |-> ##1 mem_we_i ##1 mem_we_i ##1 mem_we_i ##1 !mem_we_i)
    else $error("loader write enable not four cycles wide");

  // audio stays silent for as long as the console is in reset
  assert property (@(posedge clock) disable iff (!rst_n_i)
    reset_nes_i |-> !audio_i)
    else $error("audio active while console in reset");

endmodule

bind nes_glue_top nes_glue_chk nes_glue_chk_inst (
  .clock        (clock),
  .rst_n_i      (rst_n_i),
  .pll_locked_i (pll_locked_i),
  .load_done_i  (load_done_i),
  .mem_we_i     (mem_we_o),
  .reset_nes_i  (reset_nes_o),
  .audio_i      (audio_o)
);

`default_nettype wire

//--- tb_nes_glue.sv
`timescale 1ns/1ns
`default_nettype none

module tb_nes_glue
  import nes_glue_pkg::*;
();

  logic                clock;
  logic                rst_n;
  logic                pll_locked;
  logic                reset_button;
  logic                load_done;
  logic                loader_write;
  logic [ADDR_W-1:0]   loader_addr;
  logic [DATA_W-1:0]   loader_data;
  logic [CE_W-1:0]     nes_ce;
  logic [ADDR_W-1:0]   cpu_addr;
  logic [DATA_W-1:0]   cpu_wdata;
  logic                cpu_we;
  logic                cpu_oe;
  logic [ADDR_W-1:0]   mem_addr;
  logic [DATA_W-1:0]   mem_wdata;
  logic                mem_we;
  logic                mem_oe;
  logic                joy_strobe;
  logic                joy_clock;
  logic                board_start;
  logic                board_a;
  logic [7:0]          usb_buttons;
  logic                joy_data;
  logic [SAMPLE_W-1:0] sample;
  logic                audio;
  logic                reset_nes;

  nes_glue_top nes_glue_top_inst (
    .clock          (clock),
    .rst_n_i        (rst_n),
    .pll_locked_i   (pll_locked),
    .reset_button_i (reset_button),
    .load_done_i    (load_done),
    .loader_write_i (loader_write),
    .loader_addr_i  (loader_addr),
    .loader_data_i  (loader_data),
    .nes_ce_i       (nes_ce),
    .cpu_addr_i     (cpu_addr),
    .cpu_wdata_i    (cpu_wdata),
    .cpu_we_i       (cpu_we),
    .cpu_oe_i       (cpu_oe),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata),
    .mem_we_o       (mem_we),
    .mem_oe_o       (mem_oe),
    .joy_strobe_i   (joy_strobe),
    .joy_clock_i    (joy_clock),
    .board_start_i  (board_start),
    .board_a_i      (board_a),
    .usb_buttons_i  (usb_buttons),
    .joy_data_o     (joy_data),
    .sample_i       (sample),
    .audio_o        (audio),
    .reset_nes_o    (reset_nes)
  );

  initial
  begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // free-running console clock-enable phase
  initial
  begin
    nes_ce = '0;
    forever
    begin
      @(negedge clock);
      nes_ce = nes_ce + 1'b1;
    end
  end

  task automatic stop_failed(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      stop_failed($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_byte(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp)
      stop_failed($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                            input logic [ADDR_W-1:0] act);
    if (act !== exp)
      stop_failed($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_count(input string name, input int lo, input int hi, input int act);
    if (act < lo || act > hi)
      stop_failed($sformatf("** Error %s: expected %0d to %0d, actual %0d",
                            name, lo, hi, act));
  endtask

  // counts cycles until the console leaves reset
  task automatic wait_release(input string name, input int lo, input int hi);
    int cycles;
    cycles = 0;
    while (reset_nes === 1'b1)
    begin
      if (cycles > hi)
        stop_failed($sformatf("%s: timeout, console reset never released", name));
      @(negedge clock);
      cycles++;
    end
    check_count(name, lo, hi, cycles);
  endtask

  task automatic test_reset_hold();
    repeat (300)
    begin
      @(negedge clock);
      check_bit("reset hold", 1'b1, reset_nes);   // no download yet
    end
  endtask

  task automatic test_loader_writes();
    logic [ADDR_W-1:0] exp_addr;
    logic [DATA_W-1:0] exp_data;
    int                steps;
    int                high;
    for (int i = 0; i < 8; i++)
    begin
      exp_addr     = ADDR_W'($urandom);
      exp_data     = DATA_W'($urandom);
      loader_addr  = exp_addr;
      loader_data  = exp_data;
      loader_write = 1'b1;
      steps = 0;
      @(negedge clock);
      loader_write = 1'b0;
      loader_addr  = ADDR_W'($urandom);   // capture must not follow the bus
      loader_data  = DATA_W'($urandom);
      steps++;
      while (!mem_we)
      begin
        if (steps > 8)
          stop_failed("loader write: mem_we_o never rose after the strobe");
        @(negedge clock);
        steps++;
      end
      check_addr("loader write addr", exp_addr, mem_addr);
      check_byte("loader write data", exp_data, mem_wdata);
      check_bit("loader write oe", 1'b0, mem_oe);
      high = 0;
      while (mem_we)
      begin
        high++;
        if (high > 8)
          stop_failed("loader write: mem_we_o stuck high");
        @(negedge clock);
        steps++;
      end
      check_count("loader write width", 4, 4, high);
      while (steps < 10)
      begin
        @(negedge clock);
        steps++;
      end
    end
  endtask

  task automatic test_load_release();
    check_bit("load release before", 1'b1, reset_nes);
    load_done = 1'b1;
    wait_release("load release latency", DL_RESET_CYCLES, DL_RESET_CYCLES + 4);
  endtask

  task automatic test_cpu_port();
    for (int i = 0; i < 16; i++)
    begin
      @(negedge clock);
      cpu_addr  = ADDR_W'($urandom);
      cpu_wdata = DATA_W'($urandom);
      cpu_we    = 1'($urandom);
      cpu_oe    = 1'($urandom);
      #1;   // combinational path settles
      check_addr("cpu addr", cpu_addr, mem_addr);
      check_byte("cpu data", cpu_wdata, mem_wdata);
      check_bit("cpu we", cpu_we, mem_we);
      check_bit("cpu oe", cpu_oe, mem_oe);
    end
    @(negedge clock);
    cpu_we = 1'b0;
    cpu_oe = 1'b0;
  endtask

  task automatic test_joypad();
    logic [7:0] exp_byte;
    exp_byte = 8'($urandom);
    @(negedge clock);
    usb_buttons = exp_byte;
    board_start = 1'b1;
    board_a     = 1'b0;
    @(negedge clock);
    joy_strobe = 1'b1;   // board buttons registered by now
    @(negedge clock);
    joy_strobe = 1'b0;
    @(negedge clock);
    exp_byte[BTN_START] = 1'b1;
    for (int i = 0; i < 8; i++)
    begin
      check_bit($sformatf("joypad bit %0d", i), exp_byte[0], joy_data);
      joy_clock = 1'b1;
      @(negedge clock);
      joy_clock = 1'b0;
      @(negedge clock);
      exp_byte = {1'b0, exp_byte[7:1]};   // zeros come in behind
    end
    check_bit("joypad after eight shifts", 1'b0, joy_data);
    board_start = 1'b0;
  endtask

  task automatic measure_density(input int k);
    int ones;
    @(negedge clock);
    sample = SAMPLE_W'(k * 256);
    repeat (4) @(negedge clock);
    ones = 0;
    repeat (256)
    begin
      @(negedge clock);
      if (audio)
        ones++;
    end
    check_count($sformatf("audio density k=%0d", k), k, k, ones);
  endtask

  // the last sample stays applied so the reset tests see a busy dac
  task automatic test_audio_density();
    check_bit("audio console running", 1'b0, reset_nes);
    measure_density(1);
    measure_density(64);
    measure_density(128);
    measure_density(200);
  endtask

  task automatic test_reset_button();
    int cycles;
    @(negedge clock);
    reset_button = 1'b1;
    cycles = 0;
    while (!reset_nes)
    begin
      if (cycles > 4)
        stop_failed("reset button: console reset did not assert");
      @(negedge clock);
      cycles++;
    end
    repeat (3) @(negedge clock);
    check_bit("reset button held", 1'b1, reset_nes);
    check_bit("reset button audio", 1'b0, audio);
    reset_button = 1'b0;
    wait_release("power-on repeat", POR_CYCLES + DL_RESET_CYCLES,
                 POR_CYCLES + DL_RESET_CYCLES + 4);
  endtask

  task automatic test_lock_loss();
    @(negedge clock);
    pll_locked = 1'b0;
    @(negedge clock);
    check_bit("lock loss", 1'b1, reset_nes);
    pll_locked = 1'b1;
    // download flag is gone, so no release without a new strobe
    repeat (POR_CYCLES + DL_RESET_CYCLES + 8)
    begin
      @(negedge clock);
      check_bit("lock loss hold", 1'b1, reset_nes);
    end
  endtask

  initial
  begin
    rst_n        = 1'b0;
    pll_locked   = 1'b0;
    reset_button = 1'b0;
    load_done    = 1'b0;
    loader_write = 1'b0;
    loader_addr  = '0;
    loader_data  = '0;
    cpu_addr     = '0;
    cpu_wdata    = '0;
    cpu_we       = 1'b0;
    cpu_oe       = 1'b0;
    joy_strobe   = 1'b0;
    joy_clock    = 1'b0;
    board_start  = 1'b0;
    board_a      = 1'b0;
    usb_buttons  = '0;
    sample       = '0;
    void'($urandom(9));
    repeat (2) @(negedge clock);
    rst_n      = 1'b1;
    pll_locked = 1'b1;
    test_reset_hold();
    test_loader_writes();
    test_load_release();
    test_cpu_port();
    test_joypad();
    test_audio_density();
    test_reset_button();
    test_lock_loss();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
nes_glue_pkg.sv
reset_sequencer.sv
load_write_stage.sv
joypad_serializer.sv
sigma_delta_dac.sv
nes_glue_top.sv
nes_glue_chk.sv
tb_nes_glue.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_nes_glue
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
